// File: sources.f
+incdir+design
design/mem_ctl_pkg.sv
design/dual_port_ram.sv
design/sdram_req_decode.sv
design/sdram_sequencer.sv
design/sdram_result.sv
design/dram_app_model.sv
design/vram_port.sv
design/ram_controller.sv
bench/clock_gen.sv
bench/ram_controller_tb.sv

// File: Makefile
# Verilator build and run of the memory controller testbench

SRCS := sources.f $(wildcard design/*.sv design/*.svh bench/*.sv)
BIN := obj_dir/Vram_controller_tb

.PHONY: all run clean

all: run

$(BIN): $(SRCS)
	verilator --binary --timing --assert -f sources.f \
		--top-module ram_controller_tb --Mdir obj_dir -o Vram_controller_tb

run: $(BIN)
	./$(BIN) > sim.log 2>&1 || true
	cat sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

// File: bench/ram_controller_tb.sv
// stops at the first mismatch or timeout; expected main memory follows the stand-in's low address bits
`timescale 1ns/1ps
`include "mem_ctl_consts.svh"

module ram_controller_tb;

   localparam int TIMEOUT = 64;
   localparam int N_WORDS = 16;
   localparam int N_PAIRS = 6;
   localparam int N_VRAM = 4;

   logic                        clk;
   logic                        reset;
   logic                        sdram_req;
   logic                        sdram_write;
   logic [`SDRAM_ADDR_BITS-1:0] sdram_addr;
   mem_ctl_pkg::word_t          sdram_data_in;
   mem_ctl_pkg::word_t          sdram_data_out;
   logic                        sdram_ready;
   logic                        sdram_done;
   logic                        vram_cpu_req;
   logic                        vram_cpu_write;
   logic [`VRAM_ADDR_BITS-1:0]  vram_cpu_addr;
   mem_ctl_pkg::word_t          vram_cpu_data_in;
   mem_ctl_pkg::word_t          vram_cpu_data_out;
   logic                        vram_cpu_ready;
   logic                        vram_vga_req;
   logic [`VRAM_ADDR_BITS-1:0]  vram_vga_addr;
   mem_ctl_pkg::word_t          vram_vga_data_out;
   logic                        vram_vga_ready;

   logic [31:0]                 lfsr;
   // expected stand-in contents, aliases share a slot
   mem_ctl_pkg::word_t          scoreboard [2**`DRAM_MODEL_ADDR_BITS];
   logic [`SDRAM_ADDR_BITS-1:0] written [$];
   logic [`VRAM_ADDR_BITS-1:0]  vram_addrs [N_VRAM];
   mem_ctl_pkg::word_t          vram_words [N_VRAM];

   clock_gen u_clk (
      .clk   (clk),
      .reset (reset)
   );

   ram_controller UUT (
      .clk               (clk),
      .reset             (reset),
      .sdram_req         (sdram_req),
      .sdram_write       (sdram_write),
      .sdram_addr        (sdram_addr),
      .sdram_data_in     (sdram_data_in),
      .sdram_data_out    (sdram_data_out),
      .sdram_ready       (sdram_ready),
      .sdram_done        (sdram_done),
      .vram_cpu_req      (vram_cpu_req),
      .vram_cpu_write    (vram_cpu_write),
      .vram_cpu_addr     (vram_cpu_addr),
      .vram_cpu_data_in  (vram_cpu_data_in),
      .vram_cpu_data_out (vram_cpu_data_out),
      .vram_cpu_ready    (vram_cpu_ready),
      .vram_vga_req      (vram_vga_req),
      .vram_vga_addr     (vram_vga_addr),
      .vram_vga_data_out (vram_vga_data_out),
      .vram_vga_ready    (vram_vga_ready)
   );

   //////////////////////////////////////////////////
   // checking

   task automatic stop_with_error(input string msg);
      $display("%s", msg);
      $display("Test failed");
      $fatal(1);
   endtask

   task automatic expect_word(input string name, input mem_ctl_pkg::word_t got,
                              input mem_ctl_pkg::word_t exp);
      assert (got === exp)
      else stop_with_error($sformatf("FAIL %s got %h expected %h", name, got, exp));
   endtask

   task automatic expect_bit(input string name, input logic got, input logic exp);
      assert (got === exp)
      else stop_with_error($sformatf("FAIL %s got %h expected %h", name, got, exp));
   endtask

   //////////////////////////////////////////////////
   // random stimulus

   // fibonacci, taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // one step per bit taken
   task automatic draw_bits(input int nbits, output logic [31:0] value);
      value = '0;
      for (int i = 0; i < nbits; i++) begin
         lfsr = lfsr_next(lfsr);
         value = {value[30:0], lfsr[0]};
      end
   endtask

   // region bits zero
   task automatic pick_in_range(output logic [`SDRAM_ADDR_BITS-1:0] addr);
      logic [31:0] bits;
      draw_bits(`SDRAM_REGION_LSB, bits);
      addr = '0;
      addr[`SDRAM_REGION_LSB-1:0] = bits[`SDRAM_REGION_LSB-1:0];
   endtask

   // stand-in word picked by the low address bits
   function automatic logic [`DRAM_MODEL_ADDR_BITS-1:0] model_slot(
      input logic [`SDRAM_ADDR_BITS-1:0] addr);
      return addr[`DRAM_MODEL_ADDR_BITS-1:0];
   endfunction

   //////////////////////////////////////////////////
   // main-memory handshake

   function automatic string ack_name(input bit wr);
      if (wr)
         return "sdram_done";
      else
         return "sdram_ready";
   endfunction

   function automatic logic ack_level(input bit wr);
      return wr ? sdram_done : sdram_ready;
   endfunction

   // levels are exclusive, raising one drops the other
   task automatic raise_request(input bit wr, input logic [`SDRAM_ADDR_BITS-1:0] addr,
                                input mem_ctl_pkg::word_t data);
      sdram_addr = addr;
      sdram_data_in = data;
      sdram_req = !wr;
      sdram_write = wr;
   endtask

   task automatic drop_request();
      sdram_req = 1'b0;
      sdram_write = 1'b0;
   endtask

   task automatic await_ack(input bit wr);
      int cycles;
      cycles = 0;
      do begin
         @(negedge clk);
         cycles++;
         // other ack stays low meanwhile
         expect_bit(ack_name(!wr), ack_level(!wr), 1'b0);
         if (cycles > TIMEOUT)
            stop_with_error($sformatf("timeout waiting for %s", ack_name(wr)));
      end while (!ack_level(wr));
   endtask

   // ack is a level while the request is held
   task automatic hold_ack(input bit wr, input int n);
      repeat (n) begin
         @(negedge clk);
         expect_bit(ack_name(wr), ack_level(wr), 1'b1);
      end
   endtask

   task automatic sdram_transfer(input bit wr, input logic [`SDRAM_ADDR_BITS-1:0] addr,
                                 input mem_ctl_pkg::word_t data,
                                 input mem_ctl_pkg::word_t exp);
      raise_request(wr, addr, data);
      await_ack(wr);
      if (!wr)
         expect_word("sdram_data_out", sdram_data_out, exp);
      hold_ack(wr, 2);
      drop_request();
      // falls one edge after the drop
      @(negedge clk);
      expect_bit(ack_name(wr), ack_level(wr), 1'b0);
   endtask

   //////////////////////////////////////////////////
   // video RAM

   // write takes effect on the next rising edge, no ack
   task automatic vram_cpu_store(input logic [`VRAM_ADDR_BITS-1:0] addr,
                                 input mem_ctl_pkg::word_t data);
      vram_cpu_addr = addr;
      vram_cpu_data_in = data;
      vram_cpu_write = 1'b1;
      @(negedge clk);
      vram_cpu_write = 1'b0;
   endtask

   function automatic logic vram_ready_level(input bit vga);
      return vga ? vram_vga_ready : vram_cpu_ready;
   endfunction

   // falling edges from the request to ready
   task automatic cycles_to_ready(input bit vga, output int cycles);
      cycles = 0;
      do begin
         @(negedge clk);
         cycles++;
         if (cycles > TIMEOUT)
            stop_with_error("timeout waiting for video RAM ready to rise");
      end while (!vram_ready_level(vga));
   endtask

   task automatic await_ready_low(input bit vga);
      int cycles;
      cycles = 0;
      while (vram_ready_level(vga)) begin
         @(negedge clk);
         cycles++;
         if (cycles > TIMEOUT)
            stop_with_error("timeout waiting for video RAM ready to fall");
      end
   endtask

   //////////////////////////////////////////////////
   // sequence

   initial begin
      int                          cycles;
      int                          idx;
      logic [31:0]                 bits;
      logic [`SDRAM_ADDR_BITS-1:0] addr;
      logic [`SDRAM_ADDR_BITS-1:0] far_addr;
      mem_ctl_pkg::word_t          data;

      lfsr = 32'hc12f4f01;
      sdram_req = 1'b0;
      sdram_write = 1'b0;
      sdram_addr = '0;
      sdram_data_in = '0;
      vram_cpu_req = 1'b0;
      vram_cpu_write = 1'b0;
      vram_cpu_addr = '0;
      vram_cpu_data_in = '0;
      vram_vga_req = 1'b0;
      vram_vga_addr = '0;

      // reset changes on a falling edge, sampled on rising ones
      cycles = 0;
      do begin
         @(posedge clk);
         cycles++;
         if (cycles > TIMEOUT)
            stop_with_error("reset was never released");
      end while (reset);
      @(negedge clk);

      // idle outputs after reset
      expect_bit("sdram_ready", sdram_ready, 1'b0);
      expect_bit("sdram_done", sdram_done, 1'b0);
      expect_bit("app_en", UUT.app_en, 1'b0);
      expect_bit("vram_cpu_ready", vram_cpu_ready, 1'b0);
      expect_bit("vram_vga_ready", vram_vga_ready, 1'b0);
      expect_word("sdram_data_out", sdram_data_out, '0);

      // random in-range writes
      for (int i = 0; i < N_WORDS; i++) begin
         pick_in_range(addr);
         draw_bits(32, data);
         sdram_transfer(1'b1, addr, data, '0);
         scoreboard[model_slot(addr)] = data;
         written.push_back(addr);
      end
      // reads back at random written addresses
      for (int i = 0; i < N_WORDS; i++) begin
         draw_bits(8, bits);
         idx = int'(bits) % written.size();
         addr = written[idx];
         sdram_transfer(1'b0, addr, '0, scoreboard[model_slot(addr)]);
      end

      // out of range read, region bits nonzero
      pick_in_range(far_addr);
      draw_bits(`SDRAM_ADDR_BITS - `SDRAM_REGION_LSB, bits);
      far_addr[`SDRAM_ADDR_BITS-1:`SDRAM_REGION_LSB] =
         bits[`SDRAM_ADDR_BITS-`SDRAM_REGION_LSB-1:0];
      far_addr[`SDRAM_REGION_LSB] = 1'b1;
      sdram_transfer(1'b0, far_addr, '0, 32'hffffffff);

      // dropped write sharing low bits with live data
      addr = written[0];
      far_addr = addr;
      far_addr[`SDRAM_ADDR_BITS-1] = 1'b1;
      draw_bits(32, data);
      sdram_transfer(1'b1, far_addr, data, '0);
      sdram_transfer(1'b0, addr, '0, scoreboard[model_slot(addr)]);

      // back to back, each drop and the next raise on one edge
      for (int i = 0; i < N_PAIRS; i++) begin
         pick_in_range(addr);
         draw_bits(32, data);
         raise_request(1'b1, addr, data);
         scoreboard[model_slot(addr)] = data;
         await_ack(1'b1);
         raise_request(1'b0, addr, '0);
         await_ack(1'b0);
         expect_word("sdram_data_out", sdram_data_out, scoreboard[model_slot(addr)]);
      end
      drop_request();
      @(negedge clk);
      expect_bit("sdram_ready", sdram_ready, 1'b0);

      // processor side of the video RAM
      for (int i = 0; i < N_VRAM; i++) begin
         draw_bits(`VRAM_ADDR_BITS, bits);
         // distinct low bits keep the entries apart
         vram_addrs[i] = {bits[`VRAM_ADDR_BITS-1:2], 2'(i)};
         draw_bits(32, bits);
         vram_words[i] = bits;
         vram_cpu_store(vram_addrs[i], vram_words[i]);
         vram_cpu_req = 1'b1;
         cycles_to_ready(1'b0, cycles);
         expect_word("vram_cpu_ready delay", cycles, `VRAM_CPU_DELAY);
         expect_word("vram_cpu_data_out", vram_cpu_data_out, vram_words[i]);
         vram_cpu_req = 1'b0;
         await_ready_low(1'b0);
      end

      // display side, word held after the request drops
      for (int i = 0; i < N_VRAM; i++) begin
         vram_vga_addr = vram_addrs[i];
         vram_vga_req = 1'b1;
         cycles_to_ready(1'b1, cycles);
         expect_word("vram_vga_ready delay", cycles, `VRAM_VGA_DELAY);
         expect_word("vram_vga_data_out", vram_vga_data_out, vram_words[i]);
         vram_vga_req = 1'b0;
         vram_vga_addr = '0;
         repeat (3) begin
            @(negedge clk);
            expect_bit("vram_vga_ready", vram_vga_ready, 1'b0);
            expect_word("vram_vga_data_out", vram_vga_data_out, vram_words[i]);
         end
      end

      $display("Test completed successfully");
      $finish;
   end

endmodule

// File: bench/clock_gen.sv
// 4 ns clock from time zero; reset high for the first 16 rising edges, released on a falling edge
`timescale 1ns/1ps

module clock_gen (
   output logic clk,
   output logic reset
);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // synchronous reset, dropped away from the rising edge
   initial begin
      reset = 1'b1;
      repeat (16) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
   end

endmodule

// File: design/ram_controller.sv
// one clock for all ports; main memory backed by the behavioural DDR stand-in
`timescale 1ns/1ps
`include "mem_ctl_consts.svh"

module ram_controller (
   input  logic                        clk,
   input  logic                        reset,
   // main memory
   input  logic                        sdram_req,
   input  logic                        sdram_write,
   input  logic [`SDRAM_ADDR_BITS-1:0] sdram_addr,
   input  mem_ctl_pkg::word_t          sdram_data_in,
   output mem_ctl_pkg::word_t          sdram_data_out,
   output logic                        sdram_ready,
   output logic                        sdram_done,
   // video RAM, processor side
   input  logic                        vram_cpu_req,
   input  logic                        vram_cpu_write,
   input  logic [`VRAM_ADDR_BITS-1:0]  vram_cpu_addr,
   input  mem_ctl_pkg::word_t          vram_cpu_data_in,
   output mem_ctl_pkg::word_t          vram_cpu_data_out,
   output logic                        vram_cpu_ready,
   // video RAM, display side
   input  logic                        vram_vga_req,
   input  logic [`VRAM_ADDR_BITS-1:0]  vram_vga_addr,
   output mem_ctl_pkg::word_t          vram_vga_data_out,
   output logic                        vram_vga_ready
);

   logic                    cmd_valid;
   logic                    cmd_take;
   logic                    seq_idle;
   mem_ctl_pkg::sdram_cmd_t cmd;
   logic                    app_en;
   mem_ctl_pkg::app_cmd_t   app_cmd;
   logic                    app_rdy;
   logic                    app_wdf_rdy;
   logic                    app_rd_valid;
   mem_ctl_pkg::word_t      app_rd_data;
   logic                    rd_capture;
   logic                    hold_read;
   logic                    hold_write;

   //////////////////////////////////////////////////
   // main-memory path

   sdram_req_decode u_decode (
      .clk           (clk),
      .reset         (reset),
      .sdram_req     (sdram_req),
      .sdram_write   (sdram_write),
      .sdram_addr    (sdram_addr),
      .sdram_data_in (sdram_data_in),
      .seq_idle      (seq_idle),
      .cmd_take      (cmd_take),
      .cmd_valid     (cmd_valid),
      .cmd           (cmd)
   );

   sdram_sequencer u_seq (
      .clk          (clk),
      .reset        (reset),
      .cmd_valid    (cmd_valid),
      .cmd          (cmd),
      .sdram_req    (sdram_req),
      .sdram_write  (sdram_write),
      .cmd_take     (cmd_take),
      .seq_idle     (seq_idle),
      .app_en       (app_en),
      .app_cmd      (app_cmd),
      .app_rdy      (app_rdy),
      .app_wdf_rdy  (app_wdf_rdy),
      .app_rd_valid (app_rd_valid),
      .rd_capture   (rd_capture),
      .hold_read    (hold_read),
      .hold_write   (hold_write)
   );

   sdram_result u_result (
      .clk            (clk),
      .reset          (reset),
      .cmd            (cmd),
      .rd_capture     (rd_capture),
      .app_rd_data    (app_rd_data),
      .hold_read      (hold_read),
      .hold_write     (hold_write),
      .sdram_data_out (sdram_data_out),
      .sdram_ready    (sdram_ready),
      .sdram_done     (sdram_done)
   );

   // stand-in for the DDR core
   dram_app_model u_dram (
      .clk          (clk),
      .reset        (reset),
      .app_en       (app_en),
      .app_cmd      (app_cmd),
      .app_rdy      (app_rdy),
      .app_wdf_rdy  (app_wdf_rdy),
      .app_rd_valid (app_rd_valid),
      .app_rd_data  (app_rd_data)
   );

   //////////////////////////////////////////////////
   // video RAM

   vram_port u_vram (
      .clk               (clk),
      .reset             (reset),
      .vram_cpu_req      (vram_cpu_req),
      .vram_cpu_write    (vram_cpu_write),
      .vram_cpu_addr     (vram_cpu_addr),
      .vram_cpu_data_in  (vram_cpu_data_in),
      .vram_cpu_data_out (vram_cpu_data_out),
      .vram_cpu_ready    (vram_cpu_ready),
      .vram_vga_req      (vram_vga_req),
      .vram_vga_addr     (vram_vga_addr),
      .vram_vga_data_out (vram_vga_data_out),
      .vram_vga_ready    (vram_vga_ready)
   );

endmodule

// File: design/vram_port.sv
// single-clock video RAM; cpu writes have no acknowledge, display side is read only
`timescale 1ns/1ps
`include "mem_ctl_consts.svh"

module vram_port (
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       vram_cpu_req,
   input  logic                       vram_cpu_write,
   input  logic [`VRAM_ADDR_BITS-1:0] vram_cpu_addr,
   input  mem_ctl_pkg::word_t         vram_cpu_data_in,
   output mem_ctl_pkg::word_t         vram_cpu_data_out,
   output logic                       vram_cpu_ready,
   input  logic                       vram_vga_req,
   input  logic [`VRAM_ADDR_BITS-1:0] vram_vga_addr,
   output mem_ctl_pkg::word_t         vram_vga_data_out,
   output logic                       vram_vga_ready
);

   logic [`VRAM_CPU_DELAY-1:0] cpu_dly;
   logic [`VRAM_VGA_DELAY-1:0] vga_dly;
   mem_ctl_pkg::vram_word_t    cpu_rdata;
   mem_ctl_pkg::vram_word_t    vga_rdata;
   mem_ctl_pkg::vram_word_t    vga_hold;

   //////////////////////////////////////////////////
   // ready delay lines, bit 0 takes the request
   always_ff @(posedge clk) begin
      if (reset) begin
         cpu_dly <= '0;
         vga_dly <= '0;
      end else begin
         cpu_dly[0] <= vram_cpu_req;
         vga_dly[0] <= vram_vga_req;
         for (int i = 1; i < `VRAM_CPU_DELAY; i++)
            cpu_dly[i] <= cpu_dly[i-1];
         for (int i = 1; i < `VRAM_VGA_DELAY; i++)
            vga_dly[i] <= vga_dly[i-1];
      end
   end

   assign vram_cpu_ready = cpu_dly[`VRAM_CPU_DELAY-1];
   assign vram_vga_ready = vga_dly[`VRAM_VGA_DELAY-1];

   // last display word seen while ready
   always_ff @(posedge clk) begin
      if (vram_vga_ready)
         vga_hold <= vga_rdata;
   end

   assign vram_vga_data_out = vram_vga_ready ? mem_ctl_pkg::word_t'(vga_rdata)
                                             : mem_ctl_pkg::word_t'(vga_hold);
   assign vram_cpu_data_out = mem_ctl_pkg::word_t'(cpu_rdata);

   // display port reads on every edge
   dual_port_ram #(
      .word_type (mem_ctl_pkg::vram_word_t),
      .addr_bits (`VRAM_ADDR_BITS)
   ) u_vram (
      .clk     (clk),
      .a_en    (vram_cpu_req || vram_cpu_write),
      .a_we    (vram_cpu_write),
      .a_addr  (vram_cpu_addr),
      .a_wdata (mem_ctl_pkg::vram_word_t'(vram_cpu_data_in)),
      .a_rdata (cpu_rdata),
      .b_en    (1'b1),
      .b_addr  (vram_vga_addr),
      .b_rdata (vga_rdata)
   );

endmodule

// File: design/dram_app_model.sv
// behavioural DDR app interface; needs DRAM_READ_LATENCY >= 2, no refresh or calibration
`timescale 1ns/1ps
`include "mem_ctl_consts.svh"

module dram_app_model (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  app_en,
   input  mem_ctl_pkg::app_cmd_t app_cmd,
   output logic                  app_rdy,
   output logic                  app_wdf_rdy,
   output logic                  app_rd_valid,
   output mem_ctl_pkg::word_t    app_rd_data
);

   localparam int LAT = `DRAM_READ_LATENCY;

   logic               busy;
   logic               accept;
   logic               rd_accept;
   logic [LAT-1:0]     rd_vld;
   mem_ctl_pkg::word_t ram_rdata;
   mem_ctl_pkg::word_t rd_pipe [1:LAT-1];

   // one idle cycle after every accepted command
   assign app_rdy = !busy;
   assign app_wdf_rdy = !busy;
   assign accept = app_en && app_rdy;
   assign rd_accept = accept && (app_cmd.app_op == mem_ctl_pkg::SDRAM_READ);

   always_ff @(posedge clk) begin
      if (reset) begin
         busy <= 1'b0;
         rd_vld <= '0;
      end else begin
         busy <= accept;
         // valid bits walk the pipe, several reads may be in flight
         rd_vld <= {rd_vld[LAT-2:0], rd_accept};
      end
   end

   // data follows its valid bit, stage 0 is the RAM output
   always_ff @(posedge clk) begin
      rd_pipe[1] <= ram_rdata;
      for (int i = 2; i < LAT; i++)
         rd_pipe[i] <= rd_pipe[i-1];
   end

   assign app_rd_valid = rd_vld[LAT-1];
   assign app_rd_data = rd_pipe[LAT-1];

   // writes on port a, reads on port b
   dual_port_ram #(
      .word_type (mem_ctl_pkg::word_t),
      .addr_bits (`DRAM_MODEL_ADDR_BITS)
   ) u_mem (
      .clk     (clk),
      .a_en    (accept && (app_cmd.app_op == mem_ctl_pkg::SDRAM_WRITE)),
      .a_we    (1'b1),
      .a_addr  (app_cmd.app_addr),
      .a_wdata (app_cmd.app_wdata),
      .a_rdata (),
      .b_en    (rd_accept),
      .b_addr  (app_cmd.app_addr),
      .b_rdata (ram_rdata)
   );

   a_en_rdy: assert property (@(posedge clk) disable iff (reset) app_en |-> app_rdy);

endmodule

// File: design/sdram_result.sv
// read data is kept on sdram_data_out until the next read completes
`timescale 1ns/1ps

module sdram_result (
   input  logic                    clk,
   input  logic                    reset,
   input  mem_ctl_pkg::sdram_cmd_t cmd,
   input  logic                    rd_capture,
   input  mem_ctl_pkg::word_t      app_rd_data,
   input  logic                    hold_read,
   input  logic                    hold_write,
   output mem_ctl_pkg::word_t      sdram_data_out,
   output logic                    sdram_ready,
   output logic                    sdram_done
);

   mem_ctl_pkg::word_t rd_word;

   // outside the low region reads see all ones
   assign rd_word = cmd.in_range ? app_rd_data : '1;

   //////////////////////////////////////////////////
   // data register
   always_ff @(posedge clk) begin
      if (reset)
         sdram_data_out <= '0;
      else if (rd_capture)
         sdram_data_out <= rd_word;
   end

   //////////////////////////////////////////////////
   // ready for reads, done for writes
   always_ff @(posedge clk) begin
      if (reset) begin
         sdram_ready <= 1'b0;
         sdram_done <= 1'b0;
      end else begin
         // hold inputs already fall with the request
         sdram_ready <= hold_read;
         sdram_done <= hold_write;
      end
   end

   // data is in place one edge before ready rises
   a_data_first: assert property (@(posedge clk) disable iff (reset)
      $rose(sdram_ready) |-> $past(rd_capture, 2));

endmodule

// File: design/sdram_sequencer.sv
// one command in flight; app_en is only raised when the interface can take it
`timescale 1ns/1ps
`include "mem_ctl_consts.svh"

module sdram_sequencer (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    cmd_valid,
   input  mem_ctl_pkg::sdram_cmd_t cmd,
   input  logic                    sdram_req,
   input  logic                    sdram_write,
   output logic                    cmd_take,
   output logic                    seq_idle,
   output logic                    app_en,
   output mem_ctl_pkg::app_cmd_t   app_cmd,
   input  logic                    app_rdy,
   input  logic                    app_wdf_rdy,
   input  logic                    app_rd_valid,
   output logic                    rd_capture,
   output logic                    hold_read,
   output logic                    hold_write
);

   //////////////////////////////////////////////////
   // one-hot state bits
   localparam int S_IDLE = 0;
   localparam int S_RD_ISSUE = 1;
   localparam int S_RD_BUSY = 2;
   localparam int S_RD_HOLD = 3;
   localparam int S_WR_ISSUE = 4;
   localparam int S_WR_HOLD = 5;

   localparam logic [5:0] ST_IDLE = 6'b000001;
   localparam logic [5:0] ST_RD_ISSUE = 6'b000010;
   localparam logic [5:0] ST_RD_BUSY = 6'b000100;
   localparam logic [5:0] ST_RD_HOLD = 6'b001000;
   localparam logic [5:0] ST_WR_ISSUE = 6'b010000;
   localparam logic [5:0] ST_WR_HOLD = 6'b100000;

   logic [5:0] state;
   logic [5:0] state_next;
   logic       rd_go;
   logic       wr_go;

   always_ff @(posedge clk) begin
      if (reset)
         state <= ST_IDLE;
      else
         state <= state_next;
   end

   // command transfers this cycle
   assign rd_go = state[S_RD_ISSUE] && app_rdy;
   assign wr_go = state[S_WR_ISSUE] && app_rdy && app_wdf_rdy;

   always_comb begin
      state_next = state;
      if (state[S_IDLE] && cmd_valid) begin
         if (cmd.op == mem_ctl_pkg::SDRAM_READ)
            state_next = ST_RD_ISSUE;
         // out-of-range write is dropped but still acknowledged
         else if (cmd.in_range)
            state_next = ST_WR_ISSUE;
         else
            state_next = ST_WR_HOLD;
      end
      else if (rd_go)
         state_next = ST_RD_BUSY;
      else if (state[S_RD_BUSY] && app_rd_valid)
         state_next = ST_RD_HOLD;
      else if (state[S_RD_HOLD] && !sdram_req)
         state_next = ST_IDLE;
      else if (wr_go)
         state_next = ST_WR_HOLD;
      else if (state[S_WR_HOLD] && !sdram_write)
         state_next = ST_IDLE;
   end

   assign seq_idle = state[S_IDLE];
   assign cmd_take = state[S_IDLE] && cmd_valid;
   assign app_en = rd_go || wr_go;

   // low address bits select the stand-in word
   always_comb begin
      app_cmd.app_op = cmd.op;
      app_cmd.app_addr = cmd.addr[`DRAM_MODEL_ADDR_BITS-1:0];
      app_cmd.app_wdata = cmd.wdata;
   end

   assign rd_capture = state[S_RD_BUSY] && app_rd_valid;
   // drop with the request so ready and done fall one edge later
   assign hold_read = state[S_RD_HOLD] && sdram_req;
   assign hold_write = state[S_WR_HOLD] && sdram_write;

   a_onehot: assert property (@(posedge clk) disable iff (reset) $onehot(state));
   // app_en only from an issue state whose op matches the held command
   // out-of-range writes never reach the interface
   a_en_issue: assert property (@(posedge clk) disable iff (reset)
      app_en |-> ((state[S_RD_ISSUE] && cmd.op == mem_ctl_pkg::SDRAM_READ) ||
                  (state[S_WR_ISSUE] && cmd.op == mem_ctl_pkg::SDRAM_WRITE &&
                   cmd.in_range)));

endmodule

// File: design/sdram_req_decode.sv
// client must hold address and data stable while its request is high
`timescale 1ns/1ps
`include "mem_ctl_consts.svh"

module sdram_req_decode (
   input  logic                           clk,
   input  logic                           reset,
   input  logic                           sdram_req,
   input  logic                           sdram_write,
   input  logic [`SDRAM_ADDR_BITS-1:0]    sdram_addr,
   input  mem_ctl_pkg::word_t             sdram_data_in,
   input  logic                           seq_idle,
   input  logic                           cmd_take,
   output logic                           cmd_valid,
   output mem_ctl_pkg::sdram_cmd_t        cmd
);

   logic armed;
   logic capture;
   logic op_dropped;

   // one capture per request level, only toward an idle sequencer
   assign capture = (sdram_req || sdram_write) && seq_idle && !cmd_valid && armed;
   // level of the op last captured has gone low
   assign op_dropped = (cmd.op == mem_ctl_pkg::SDRAM_READ) ? !sdram_req : !sdram_write;

   always_ff @(posedge clk) begin
      if (reset) begin
         cmd_valid <= 1'b0;
         armed <= 1'b1;
      end else begin
         if (capture) begin
            cmd_valid <= 1'b1;
            armed <= 1'b0;
         end else begin
            if (cmd_take)
               cmd_valid <= 1'b0;
            // re-arm once the client lets go
            if (!armed && op_dropped)
               armed <= 1'b1;
         end
      end
   end

   // payload
   always_ff @(posedge clk) begin
      if (capture) begin
         cmd.op <= sdram_write ? mem_ctl_pkg::SDRAM_WRITE : mem_ctl_pkg::SDRAM_READ;
         cmd.addr <= sdram_addr;
         cmd.wdata <= sdram_data_in;
         // only the low region is backed by memory
         cmd.in_range <= (sdram_addr[`SDRAM_ADDR_BITS-1:`SDRAM_REGION_LSB] == '0);
      end
   end

   // client protocol: one kind of request at a time
   a_req_excl: assert property (@(posedge clk) disable iff (reset)
      !(sdram_req && sdram_write));

endmodule

// File: design/dual_port_ram.sv
// read-first RAM, port b read only; contents are not cleared by reset
`timescale 1ns/1ps

module dual_port_ram #(
   parameter type word_type = logic [31:0],
   parameter int  addr_bits = 10
) (
   input  logic                 clk,
   input  logic                 a_en,
   input  logic                 a_we,
   input  logic [addr_bits-1:0] a_addr,
   input  word_type             a_wdata,
   output word_type             a_rdata,
   input  logic                 b_en,
   input  logic [addr_bits-1:0] b_addr,
   output word_type             b_rdata
);

   word_type mem [2**addr_bits];

   // port a
   always_ff @(posedge clk) begin
      if (a_en) begin
         if (a_we)
            mem[a_addr] <= a_wdata;
         // old word on a write
         a_rdata <= mem[a_addr];
      end
   end

   // port b, output held while idle
   always_ff @(posedge clk) begin
      if (b_en)
         b_rdata <= mem[b_addr];
   end

endmodule

// File: design/mem_ctl_pkg.sv
// shared types for the memory controller; widths come from mem_ctl_consts.svh
package mem_ctl_pkg;

`include "mem_ctl_consts.svh"

   // data word on every client port
   typedef logic [31:0] word_t;

   // main-memory op
   typedef enum logic {
      SDRAM_READ  = 1'b0,
      SDRAM_WRITE = 1'b1
   } sdram_op_t;

   // decoded client request, held by decode until the next capture
   typedef struct packed {
      sdram_op_t                   op;
      logic [`SDRAM_ADDR_BITS-1:0] addr;
      word_t                       wdata;
      logic                        in_range;
   } sdram_cmd_t;

   // command toward the application interface
   typedef struct packed {
      sdram_op_t                        app_op;
      logic [`DRAM_MODEL_ADDR_BITS-1:0] app_addr;
      word_t                            app_wdata;
   } app_cmd_t;

   // four 8-bit pixels per video RAM word, pix0 in the low byte
   typedef struct packed {
      logic [7:0] pix3;
      logic [7:0] pix2;
      logic [7:0] pix1;
      logic [7:0] pix0;
   } vram_word_t;

endpackage

// File: design/mem_ctl_consts.svh
// widths and latencies shared by all blocks; DRAM_READ_LATENCY must be 2 or more
`ifndef MEM_CTL_CONSTS_SVH
`define MEM_CTL_CONSTS_SVH

// main-memory word address from the processor
`define SDRAM_ADDR_BITS 22
// address bits from here upward must be zero for an in-range access
`define SDRAM_REGION_LSB 17

// behavioural DDR stand-in, depth set by the low address bits
`define DRAM_MODEL_ADDR_BITS 10
// cycles from command acceptance to app_rd_valid
`define DRAM_READ_LATENCY 2

// video RAM
`define VRAM_ADDR_BITS 15
// ready delays in cycles, both at least 1
`define VRAM_CPU_DELAY 4
`define VRAM_VGA_DELAY 1

`endif
